/* bench/mem_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_props (
    input logic                clk,
    input logic                rst_n,
    input logic                flush,
    input logic                mem_cmd_start,
    input logic                mem_cmd_ready,
    input mem_op_pkg::word_t   mem_addr,
    input mem_op_pkg::word_t   mem_wdata,
    input mem_op_pkg::word_t   mem_wmask,
    input mem_op_pkg::mem_op_t mem_op,
    input logic                stall
);

    // Waiting request keeps its fields until accepted or flushed
    property request_stable;
        @(posedge clk) disable iff (!rst_n)
            mem_cmd_start && !mem_cmd_ready |=>
                flush || (mem_cmd_start && $stable(mem_addr) && $stable(mem_wdata)
                          && $stable(mem_wmask));
    endproperty

    // No stall last cycle means the stage is idle now
    property no_stall_idle_non_mem;
        @(posedge clk) disable iff (!rst_n)
            !$past(stall) && (mem_op == mem_op_pkg::NONE) |-> !stall;
    endproperty

    assert property (request_stable)
        else $error("memory request changed while waiting for ready");

    assert property (no_stall_idle_non_mem)
        else $error("stall high for a non-memory instruction in an idle stage");

endmodule

bind mem_stage mem_stage_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .mem_cmd_start (mem_cmd_start),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_wmask     (mem_wmask),
    .mem_op        (mem_op),
    .stall         (stall)
);

`default_nettype wire

/* bench/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module tb_mem_stage;

    localparam int MAX_INSTR = 512;

    logic                clk;
    logic                rst_n;
    logic                flush;
    mem_op_pkg::word_t   pc;
    mem_op_pkg::word_t   inst;
    mem_op_pkg::word_t   rs2_data;
    mem_op_pkg::word_t   alu_out;
    logic                br_flg;
    mem_op_pkg::word_t   br_target;
    mem_op_pkg::mem_op_t mem_op;
    logic                rf_wen;
    pipe_pkg::wb_sel_t   wb_sel;
    pipe_pkg::reg_addr_t wb_addr;
    logic                jmp_flg;
    logic                mem_cmd_start;
    logic                mem_cmd_write;
    logic                mem_cmd_ready;
    mem_op_pkg::word_t   mem_addr;
    mem_op_pkg::word_t   mem_wdata;
    mem_op_pkg::word_t   mem_wmask;
    mem_op_pkg::word_t   mem_rdata;
    logic                mem_rdata_valid;
    mem_op_pkg::word_t   out_pc;
    mem_op_pkg::word_t   out_inst;
    mem_op_pkg::word_t   out_alu_out;
    logic                out_br_flg;
    mem_op_pkg::word_t   out_br_target;
    logic                out_rf_wen;
    pipe_pkg::wb_sel_t   out_wb_sel;
    pipe_pkg::reg_addr_t out_wb_addr;
    logic                out_jmp_flg;
    mem_op_pkg::word_t   out_read_data;
    logic                fwd_rf_wen;
    pipe_pkg::reg_addr_t fwd_wb_addr;
    mem_op_pkg::word_t   cur_inst;
    mem_op_pkg::mem_op_t cur_mem_op;
    logic                stall;

    logic [31:0]         lfsr_state;
    logic [31:0]         mem [0:255];  // Word memory, index from addr[9:2]
    int                  issue_cnt;
    int                  cmp_idx;
    int                  expected_q[$];

    // Issued instructions, indexed by issue number
    mem_op_pkg::word_t   exp_pc        [MAX_INSTR];
    mem_op_pkg::word_t   exp_inst      [MAX_INSTR];
    mem_op_pkg::word_t   exp_rs2       [MAX_INSTR];
    mem_op_pkg::word_t   exp_alu       [MAX_INSTR];
    mem_op_pkg::word_t   exp_br_target [MAX_INSTR];
    mem_op_pkg::word_t   exp_read      [MAX_INSTR];
    logic                exp_br_flg    [MAX_INSTR];
    logic                exp_rf_wen    [MAX_INSTR];
    logic                exp_jmp_flg   [MAX_INSTR];
    pipe_pkg::wb_sel_t   exp_wb_sel    [MAX_INSTR];
    pipe_pkg::reg_addr_t exp_wb_addr   [MAX_INSTR];
    mem_op_pkg::mem_op_t exp_op        [MAX_INSTR];

    mem_stage u_mem_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < width; i++)
            r = {r[30:0], next_bit()};
        return r;
    endfunction

    // Load result, or the memory word after a store
    function automatic logic [31:0] expect_access(input mem_op_pkg::mem_op_t op,
                                                  input logic [31:0] word,
                                                  input logic [31:0] wdata);
        logic [31:0] result;
        case (op)
            mem_op_pkg::LB:  result = word[7] ? (word | 32'hffff_ff00) : (word & 32'h0000_00ff);
            mem_op_pkg::LBU: result = word & 32'h0000_00ff;
            mem_op_pkg::LH:  result = word[15] ? (word | 32'hffff_0000) : (word & 32'h0000_ffff);
            mem_op_pkg::LHU: result = word & 32'h0000_ffff;
            mem_op_pkg::SB:  result = (word & 32'hffff_ff00) | (wdata & 32'h0000_00ff);
            mem_op_pkg::SH:  result = (word & 32'hffff_0000) | (wdata & 32'h0000_ffff);
            mem_op_pkg::SW:  result = wdata;
            default:         result = word;
        endcase
        return result;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected));
    endtask

    task automatic drive_bubble();
        flush           = 1'b0;
        pc              = `PC_NOP;
        inst            = `INST_NOP;
        rs2_data        = '0;
        alu_out         = '0;
        br_flg          = 1'b0;
        br_target       = '0;
        mem_op          = mem_op_pkg::NONE;
        rf_wen          = 1'b0;
        wb_sel          = pipe_pkg::X;
        wb_addr         = '0;
        jmp_flg         = 1'b0;
        mem_cmd_ready   = 1'b0;
        mem_rdata       = '0;
        mem_rdata_valid = 1'b0;
    endtask

    // ==================================================
    // One instruction, with the memory model
    // ==================================================

    // kind picks ALU, branch or jump when op is NONE
    task automatic run_instr(input mem_op_pkg::mem_op_t op, input int kind,
                             input int ready_dly, input int lat, input int flush_at);
        int          n;
        int          cycle;
        int          wait_cnt;
        int          lat_cnt;
        logic        is_ld;
        logic        is_st;
        logic        accepted;
        logic        done;
        logic        exp_stall;
        logic [6:0]  opcode;
        logic [7:0]  idx;
        logic [31:0] r;
        logic [31:0] old_word;
        n = issue_cnt;
        issue_cnt++;
        is_ld = op inside {mem_op_pkg::LB, mem_op_pkg::LBU, mem_op_pkg::LH,
                           mem_op_pkg::LHU, mem_op_pkg::LW};
        is_st = op inside {mem_op_pkg::SB, mem_op_pkg::SH, mem_op_pkg::SW};
        opcode = 7'h33;
        if (kind == 1)
            opcode = 7'h63;
        if (kind == 2)
            opcode = 7'h6f;
        if (is_ld)
            opcode = 7'h03;
        if (is_st)
            opcode = 7'h23;
        r = rand_bits(25);
        exp_op[n]        = op;
        exp_pc[n]        = 32'h0001_0000 + n * 4;  // Unique per instruction
        exp_inst[n]      = {r[24:0], opcode};
        exp_rs2[n]       = rand_bits(32);
        r = rand_bits(8);
        exp_alu[n]       = (is_ld || is_st) ? (32'h0000_2000 | (r << 2)) : rand_bits(32);
        exp_br_target[n] = rand_bits(32);
        exp_br_flg[n]    = (op == mem_op_pkg::NONE && kind == 1) ? next_bit() : 1'b0;
        exp_jmp_flg[n]   = (op == mem_op_pkg::NONE && kind == 2);
        exp_rf_wen[n]    = is_ld || (op == mem_op_pkg::NONE && kind != 1);
        exp_wb_sel[n]    = pipe_pkg::X;
        if (exp_rf_wen[n])
            exp_wb_sel[n] = is_ld ? pipe_pkg::MEM : (kind == 2 ? pipe_pkg::PC : pipe_pkg::ALU);
        r = rand_bits(5);
        exp_wb_addr[n]   = r[4:0];
        exp_read[n]      = '1;

        pc        = exp_pc[n];
        inst      = exp_inst[n];
        rs2_data  = exp_rs2[n];
        alu_out   = exp_alu[n];
        br_flg    = exp_br_flg[n];
        br_target = exp_br_target[n];
        mem_op    = op;
        rf_wen    = exp_rf_wen[n];
        wb_sel    = exp_wb_sel[n];
        wb_addr   = exp_wb_addr[n];
        jmp_flg   = exp_jmp_flg[n];

        wait_cnt = ready_dly;
        lat_cnt  = lat;
        accepted = 1'b0;
        done     = 1'b0;
        idx      = '0;
        cycle    = 0;
        while (!done) begin
            flush = (cycle == flush_at);
            mem_cmd_ready = (is_ld || is_st) && !accepted && (wait_cnt == 0);
            if (wait_cnt > 0)
                wait_cnt--;
            if (is_ld && accepted)
                lat_cnt--;
            mem_rdata_valid = is_ld && accepted && (lat_cnt == 0);
            mem_rdata = mem_rdata_valid ? mem[idx] : 32'hdead_beef;
            #1;
            if (flush) begin
                // Memory side drops a read in flight as well
                check_value("mem_cmd_start", 32'(mem_cmd_start), 32'(1'b0));
                done = 1'b1;
            end else begin
                exp_stall = is_st ? !mem_cmd_ready : (is_ld ? !mem_rdata_valid : 1'b0);
                check_value("stall", 32'(stall), 32'(exp_stall));
                check_value("mem_cmd_start", 32'(mem_cmd_start), 32'((is_ld || is_st) && !accepted));
                check_value("cur_inst", cur_inst, exp_inst[n]);
                check_value("cur_mem_op", 32'(cur_mem_op), 32'(op));
                check_value("fwd_rf_wen", 32'(fwd_rf_wen), 32'(exp_rf_wen[n]));
                check_value("fwd_wb_addr", 32'(fwd_wb_addr), 32'(exp_wb_addr[n]));
                if (mem_cmd_start && mem_cmd_ready) begin
                    accepted = 1'b1;
                    check_value("mem_addr", mem_addr, exp_alu[n]);
                    check_value("mem_cmd_write", 32'(mem_cmd_write), 32'(is_st));
                    idx = mem_addr[9:2];
                    old_word = mem[idx];
                    if (is_st) begin
                        check_value("mem_wdata", mem_wdata, exp_rs2[n]);
                        mem[idx] = (old_word & ~mem_wmask) | (mem_wdata & mem_wmask);
                        check_value("memory word", mem[idx], expect_access(op, old_word, exp_rs2[n]));
                    end else begin
                        exp_read[n] = expect_access(op, old_word, '0);
                    end
                end
                if (!stall) begin
                    expected_q.push_back(n);
                    done = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            cycle++;
            if (cycle > 16)
                abort_run($sformatf("Timeout: instruction %0d never finished", n));
        end
    endtask

    task automatic run_random();
        int                  kind;
        int                  flush_at;
        mem_op_pkg::mem_op_t op;
        kind = rand_bits(3) % 5;  // 3 load, 4 store
        op = mem_op_pkg::NONE;
        if (kind == 3)
            op = mem_op_pkg::mem_op_t'(4'(1 + rand_bits(8) % 5));
        if (kind == 4)
            op = mem_op_pkg::mem_op_t'(4'(6 + rand_bits(8) % 3));
        flush_at = -1;
        if (rand_bits(3) == 0)
            flush_at = 1 + rand_bits(1);
        run_instr(op, kind, rand_bits(2), 1 + rand_bits(2), flush_at);
    endtask

    // ==================================================
    // Retirement check
    // ==================================================

    always @(negedge clk) begin
        if (rst_n && out_inst !== `INST_NOP) begin
            if (expected_q.size() == 0) begin
                abort_run("An instruction retired that was never issued");
            end else begin
                cmp_idx = expected_q.pop_front();
                check_value("out_pc", out_pc, exp_pc[cmp_idx]);
                check_value("out_inst", out_inst, exp_inst[cmp_idx]);
                check_value("out_alu_out", out_alu_out, exp_alu[cmp_idx]);
                check_value("out_br_flg", 32'(out_br_flg), 32'(exp_br_flg[cmp_idx]));
                check_value("out_br_target", out_br_target, exp_br_target[cmp_idx]);
                check_value("out_rf_wen", 32'(out_rf_wen), 32'(exp_rf_wen[cmp_idx]));
                check_value("out_wb_sel", 32'(out_wb_sel), 32'(exp_wb_sel[cmp_idx]));
                check_value("out_wb_addr", 32'(out_wb_addr), 32'(exp_wb_addr[cmp_idx]));
                check_value("out_jmp_flg", 32'(out_jmp_flg), 32'(exp_jmp_flg[cmp_idx]));
                if (exp_op[cmp_idx] inside {mem_op_pkg::LB, mem_op_pkg::LBU, mem_op_pkg::LH,
                                            mem_op_pkg::LHU, mem_op_pkg::LW})
                    check_value("out_read_data", out_read_data, exp_read[cmp_idx]);
            end
        end
    end

    initial begin
        lfsr_state = 32'd97359;
        issue_cnt  = 0;
        rst_n      = 1'b0;
        drive_bubble();
        for (int i = 0; i < 256; i++)
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #1;
        check_value("out_rf_wen", 32'(out_rf_wen), 32'(1'b0));
        check_value("out_jmp_flg", 32'(out_jmp_flg), 32'(1'b0));
        check_value("mem_cmd_start", 32'(mem_cmd_start), 32'(1'b0));
        check_value("out_inst", out_inst, `INST_NOP);
        @(posedge clk);
        #1;

        for (int i = 0; i < 9; i++)
            run_instr(mem_op_pkg::NONE, i % 3, 0, 1, -1);
        for (int i = 0; i < 12; i++)
            run_instr(mem_op_pkg::mem_op_t'(4'(6 + i % 3)), 0, rand_bits(2), 1, -1);
        for (int i = 0; i < 20; i++)
            run_instr(mem_op_pkg::mem_op_t'(4'(1 + i % 5)), 0, rand_bits(2), 1 + rand_bits(2), -1);

        // Flush on a waiting store, a load in flight and a load not yet accepted
        run_instr(mem_op_pkg::SW, 0, 3, 1, 1);
        run_instr(mem_op_pkg::NONE, 0, 0, 1, -1);
        run_instr(mem_op_pkg::LW, 0, 0, 4, 2);
        run_instr(mem_op_pkg::LH, 0, 0, 2, -1);
        run_instr(mem_op_pkg::LBU, 0, 2, 1, 1);
        run_instr(mem_op_pkg::SB, 0, 1, 1, -1);

        for (int i = 0; i < 300; i++)
            run_random();

        drive_bubble();
        @(negedge clk);
        #1;
        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d issued instructions never retired", expected_q.size()));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
source/mem_op_pkg.sv
source/pipe_pkg.sv
source/mem_access_ctrl.sv
source/mem_hold_buffer.sv
source/mem_request_format.sv
source/load_align.sv
source/mem_stage.sv
bench/mem_stage_props.sv
bench/tb_mem_stage.sv

/* include/mem_stage_defs.svh */
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// ==================================================
// Datapath
// ==================================================

`define XLEN 32

// Bubble carried down the pipe, addi x0,x0,0
`define INST_NOP 32'h0000_0013
`define PC_NOP   32'hffff_ffff

// ==================================================
// Store write masks
// ==================================================

`define MASK_BYTE 32'h0000_00ff  // SB
`define MASK_HALF 32'h0000_ffff  // SH

`endif

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_mem_stage -Mdir obj_dir

# The simulator exits non-zero on a fatal check, so capture its output first
sim_out=$(./obj_dir/Vtb_mem_stage 2>&1 || true)
echo "$sim_out"

if grep -qF "** PASS **" <<< "$sim_out"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* source/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module load_align (
    input  mem_op_pkg::mem_op_t held_mem_op,
    input  mem_op_pkg::word_t   mem_rdata,
    output mem_op_pkg::word_t   load_data
);

    // ==================================================
    // Sign or zero extension of the low bytes
    // ==================================================

    always_comb begin
        case (held_mem_op)
            mem_op_pkg::LB:
                load_data = {{(`XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
            mem_op_pkg::LBU:
                load_data = {{(`XLEN-8){1'b0}}, mem_rdata[7:0]};
            mem_op_pkg::LH:
                load_data = {{(`XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
            mem_op_pkg::LHU:
                load_data = {{(`XLEN-16){1'b0}}, mem_rdata[15:0]};
            mem_op_pkg::LW:
                load_data = mem_rdata;
            default:
                load_data = '1;  // Not a load
        endcase
    end

endmodule

`default_nettype wire

/* source/mem_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               is_store,
    input  logic               is_load,
    input  logic               mem_cmd_ready,
    input  logic               mem_rdata_valid,
    output logic               mem_cmd_start,
    output logic               stall,
    output logic               use_held,
    output logic               capture_en,
    output pipe_pkg::out_sel_t out_sel
);

    pipe_pkg::access_state_t state;
    pipe_pkg::access_state_t state_nxt;

    // ==================================================
    // Next state, command and output selection
    // ==================================================

    always_comb begin
        state_nxt     = state;
        mem_cmd_start = 1'b0;
        stall         = 1'b0;
        out_sel       = pipe_pkg::SEL_BUBBLE;

        case (state)
            pipe_pkg::IDLE: begin
                if (is_store || is_load) begin
                    mem_cmd_start = 1'b1;
                    if (!mem_cmd_ready) begin
                        state_nxt = pipe_pkg::WAIT_READY;
                        stall     = 1'b1;
                    end else if (is_load) begin
                        state_nxt = pipe_pkg::WAIT_RDATA;
                        stall     = 1'b1;
                    end else begin
                        out_sel = pipe_pkg::SEL_CUR;  // Store taken at once
                    end
                end else begin
                    out_sel = pipe_pkg::SEL_CUR;
                end
            end

            pipe_pkg::WAIT_READY: begin
                mem_cmd_start = 1'b1;  // Request held until accepted
                stall         = 1'b1;
                if (mem_cmd_ready) begin
                    if (is_store) begin
                        state_nxt = pipe_pkg::IDLE;
                        stall     = 1'b0;
                        out_sel   = pipe_pkg::SEL_HELD;
                    end else begin
                        state_nxt = pipe_pkg::WAIT_RDATA;
                    end
                end
            end

            pipe_pkg::WAIT_RDATA: begin
                if (mem_rdata_valid) begin
                    state_nxt = pipe_pkg::IDLE;
                    out_sel   = pipe_pkg::SEL_HELD;
                end else begin
                    stall = 1'b1;
                end
            end

            default: state_nxt = pipe_pkg::IDLE;
        endcase

        // Flush abandons whatever is pending
        if (flush) begin
            state_nxt     = pipe_pkg::IDLE;
            mem_cmd_start = 1'b0;
            stall         = 1'b0;
            out_sel       = pipe_pkg::SEL_BUBBLE;
        end
    end

    assign use_held   = !flush && (state != pipe_pkg::IDLE);
    assign capture_en = flush || (state == pipe_pkg::IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pipe_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* source/mem_hold_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_hold_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 capture_en,
    input  pipe_pkg::out_sel_t   out_sel,
    input  logic                 use_held,
    input  mem_op_pkg::word_t    pc,
    input  mem_op_pkg::word_t    inst,
    input  mem_op_pkg::word_t    rs2_data,
    input  mem_op_pkg::word_t    alu_out,
    input  logic                 br_flg,
    input  mem_op_pkg::word_t    br_target,
    input  mem_op_pkg::mem_op_t  mem_op,
    input  logic                 rf_wen,
    input  pipe_pkg::wb_sel_t    wb_sel,
    input  pipe_pkg::reg_addr_t  wb_addr,
    input  logic                 jmp_flg,
    input  mem_op_pkg::word_t    load_data,
    output mem_op_pkg::word_t    held_rs2_data,
    output mem_op_pkg::word_t    held_alu_out,
    output mem_op_pkg::mem_op_t  held_mem_op,
    output mem_op_pkg::word_t    out_pc,
    output mem_op_pkg::word_t    out_inst,
    output mem_op_pkg::word_t    out_alu_out,
    output logic                 out_br_flg,
    output mem_op_pkg::word_t    out_br_target,
    output logic                 out_rf_wen,
    output pipe_pkg::wb_sel_t    out_wb_sel,
    output pipe_pkg::reg_addr_t  out_wb_addr,
    output logic                 out_jmp_flg,
    output mem_op_pkg::word_t    out_read_data,
    output logic                 fwd_rf_wen,
    output pipe_pkg::reg_addr_t  fwd_wb_addr,
    output mem_op_pkg::word_t    cur_inst,
    output mem_op_pkg::mem_op_t  cur_mem_op
);

    // Flushed input reads as a bubble
    wire mem_op_pkg::word_t   in_pc        = flush ? `PC_NOP : pc;
    wire mem_op_pkg::word_t   in_inst      = flush ? `INST_NOP : inst;
    wire mem_op_pkg::word_t   in_rs2_data  = flush ? '1 : rs2_data;
    wire mem_op_pkg::word_t   in_alu_out   = flush ? '1 : alu_out;
    wire                      in_br_flg    = flush ? 1'b0 : br_flg;
    wire mem_op_pkg::word_t   in_br_target = flush ? '1 : br_target;
    wire mem_op_pkg::mem_op_t in_mem_op    = flush ? mem_op_pkg::NONE : mem_op;
    wire                      in_rf_wen    = flush ? 1'b0 : rf_wen;
    wire pipe_pkg::wb_sel_t   in_wb_sel    = flush ? pipe_pkg::X : wb_sel;
    wire pipe_pkg::reg_addr_t in_wb_addr   = flush ? '0 : wb_addr;
    wire                      in_jmp_flg   = flush ? 1'b0 : jmp_flg;

    mem_op_pkg::word_t   held_pc;
    mem_op_pkg::word_t   held_inst;
    logic                held_br_flg;
    mem_op_pkg::word_t   held_br_target;
    logic                held_rf_wen;
    pipe_pkg::wb_sel_t   held_wb_sel;
    pipe_pkg::reg_addr_t held_wb_addr;
    logic                held_jmp_flg;

    wire take_held   = (out_sel == pipe_pkg::SEL_HELD);
    wire take_bubble = (out_sel == pipe_pkg::SEL_BUBBLE);

    // ==================================================
    // Copy of the instruction for a pending access
    // ==================================================

    always_ff @(posedge clk) begin
        if (capture_en) begin
            held_pc        <= in_pc;
            held_inst      <= in_inst;
            held_rs2_data  <= in_rs2_data;
            held_alu_out   <= in_alu_out;
            held_br_flg    <= in_br_flg;
            held_br_target <= in_br_target;
            held_mem_op    <= in_mem_op;
            held_rf_wen    <= in_rf_wen;
            held_wb_sel    <= in_wb_sel;
            held_wb_addr   <= in_wb_addr;
            held_jmp_flg   <= in_jmp_flg;
        end
    end

    // Forwarding and fence view of the instruction in flight
    assign fwd_rf_wen  = use_held ? held_rf_wen : in_rf_wen;
    assign fwd_wb_addr = use_held ? held_wb_addr : in_wb_addr;
    assign cur_inst    = use_held ? held_inst : in_inst;
    assign cur_mem_op  = use_held ? held_mem_op : in_mem_op;

    // ==================================================
    // Write-back registers
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pc      <= `PC_NOP;
            out_inst    <= `INST_NOP;
            out_br_flg  <= 1'b0;
            out_rf_wen  <= 1'b0;
            out_wb_sel  <= pipe_pkg::X;
            out_wb_addr <= '0;
            out_jmp_flg <= 1'b0;
        end else begin
            out_pc      <= take_bubble ? `PC_NOP   : (take_held ? held_pc : in_pc);
            out_inst    <= take_bubble ? `INST_NOP : (take_held ? held_inst : in_inst);
            out_br_flg  <= take_bubble ? 1'b0 : (take_held ? held_br_flg : in_br_flg);
            out_rf_wen  <= take_bubble ? 1'b0 : (take_held ? held_rf_wen : in_rf_wen);
            out_wb_sel  <= take_bubble ? pipe_pkg::X : (take_held ? held_wb_sel : in_wb_sel);
            out_wb_addr <= take_bubble ? '0 : (take_held ? held_wb_addr : in_wb_addr);
            out_jmp_flg <= take_bubble ? 1'b0 : (take_held ? held_jmp_flg : in_jmp_flg);
        end
    end

    always_ff @(posedge clk) begin
        out_alu_out   <= take_bubble ? '1 : (take_held ? held_alu_out : in_alu_out);
        out_br_target <= take_bubble ? '1 : (take_held ? held_br_target : in_br_target);
        out_read_data <= take_held ? load_data : '1;  // Only a held load returns data
    end

endmodule

`default_nettype wire

/* source/mem_op_pkg.sv */
`default_nettype none

`include "mem_stage_defs.svh"

package mem_op_pkg;

    // Addresses, data words and write masks
    typedef logic [`XLEN-1:0] word_t;

    // Memory operation from decode
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_t;

endpackage

`default_nettype wire

/* source/mem_request_format.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_request_format (
    input  logic                use_held,
    input  logic                flush,
    input  mem_op_pkg::mem_op_t mem_op,
    input  mem_op_pkg::word_t   alu_out,
    input  mem_op_pkg::word_t   rs2_data,
    input  mem_op_pkg::mem_op_t held_mem_op,
    input  mem_op_pkg::word_t   held_alu_out,
    input  mem_op_pkg::word_t   held_rs2_data,
    output logic                is_store,
    output logic                is_load,
    output logic                mem_cmd_write,
    output mem_op_pkg::word_t   mem_addr,
    output mem_op_pkg::word_t   mem_wdata,
    output mem_op_pkg::word_t   mem_wmask
);

    mem_op_pkg::mem_op_t sel_op;

    assign sel_op = flush ? mem_op_pkg::NONE : (use_held ? held_mem_op : mem_op);

    // Op class
    assign is_store = sel_op inside {mem_op_pkg::SB, mem_op_pkg::SH, mem_op_pkg::SW};
    assign is_load  = sel_op inside {mem_op_pkg::LB, mem_op_pkg::LBU, mem_op_pkg::LH,
                                     mem_op_pkg::LHU, mem_op_pkg::LW};

    assign mem_cmd_write = is_store;
    assign mem_addr      = use_held ? held_alu_out : alu_out;  // Sent unaligned as computed
    assign mem_wdata     = use_held ? held_rs2_data : rs2_data;

    always_comb begin
        case (sel_op)
            mem_op_pkg::SB: mem_wmask = `MASK_BYTE;
            mem_op_pkg::SH: mem_wmask = `MASK_HALF;
            default:        mem_wmask = '1;
        endcase
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    // From execute
    input  mem_op_pkg::word_t    pc,
    input  mem_op_pkg::word_t    inst,
    input  mem_op_pkg::word_t    rs2_data,
    input  mem_op_pkg::word_t    alu_out,
    input  logic                 br_flg,
    input  mem_op_pkg::word_t    br_target,
    input  mem_op_pkg::mem_op_t  mem_op,
    input  logic                 rf_wen,
    input  pipe_pkg::wb_sel_t    wb_sel,
    input  pipe_pkg::reg_addr_t  wb_addr,
    input  logic                 jmp_flg,

    // Memory port
    output logic                 mem_cmd_start,
    output logic                 mem_cmd_write,
    input  logic                 mem_cmd_ready,
    output mem_op_pkg::word_t    mem_addr,
    output mem_op_pkg::word_t    mem_wdata,
    output mem_op_pkg::word_t    mem_wmask,
    input  mem_op_pkg::word_t    mem_rdata,
    input  logic                 mem_rdata_valid,

    // To write-back
    output mem_op_pkg::word_t    out_pc,
    output mem_op_pkg::word_t    out_inst,
    output mem_op_pkg::word_t    out_alu_out,
    output logic                 out_br_flg,
    output mem_op_pkg::word_t    out_br_target,
    output logic                 out_rf_wen,
    output pipe_pkg::wb_sel_t    out_wb_sel,
    output pipe_pkg::reg_addr_t  out_wb_addr,
    output logic                 out_jmp_flg,
    output mem_op_pkg::word_t    out_read_data,

    // Hazard, trap and fence view
    output logic                 fwd_rf_wen,
    output pipe_pkg::reg_addr_t  fwd_wb_addr,
    output mem_op_pkg::word_t    cur_inst,
    output mem_op_pkg::mem_op_t  cur_mem_op,

    output logic                 stall
);

    // ==================================================
    // Controller to datapath
    // ==================================================

    logic                is_store;
    logic                is_load;
    logic                use_held;
    logic                capture_en;
    pipe_pkg::out_sel_t  out_sel;

    mem_op_pkg::word_t   held_rs2_data;
    mem_op_pkg::word_t   held_alu_out;
    mem_op_pkg::mem_op_t held_mem_op;
    mem_op_pkg::word_t   load_data;

    // Port names line up with the signals above
    mem_access_ctrl u_ctrl (.*);

    mem_hold_buffer u_hold (.*);

    mem_request_format u_req (.*);

    load_align u_align (.*);

endmodule

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    typedef logic [4:0] reg_addr_t;

    // Write-back source
    typedef enum logic [3:0] {
        X   = 4'd0,
        ALU = 4'd1,
        MEM = 4'd2,
        PC  = 4'd3,
        CSR = 4'd4
    } wb_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_RDATA
    } access_state_t;

    // What the output registers load
    typedef enum logic [1:0] {
        SEL_BUBBLE,
        SEL_CUR,
        SEL_HELD
    } out_sel_t;

endpackage

`default_nettype wire
